//--- verilog/phold_pkg.sv
// event message format and generation constants for the PHOLD core
package phold_pkg;

   localparam int TIME_W = 16;
   localparam int NB_LPID = 3;
   localparam int MSG_W = 32;
   localparam int NB_RND = 24;

   // minimum time advance of a generated event
   localparam int MIN_GAP = 10;
   // base processing delay in cycles
   localparam int FIXED_DELAY = 10;

   typedef logic [TIME_W-1:0] time_t;
   typedef logic [NB_LPID-1:0] lp_id_t;
   typedef logic [NB_RND-1:0] rnd_t;

   typedef enum logic {
      EVT_REGULAR = 1'b0,
      EVT_CANCEL  = 1'b1
   } evt_type_t;

   // final flag on top and time in the low bits
   typedef struct packed {
      logic                           is_final;
      logic [MSG_W-NB_LPID-TIME_W-3:0] pad;
      evt_type_t                      evt_type;
      lp_id_t                         target;
      time_t                          evt_time;
   } evt_msg_t;

endpackage

//--- verilog/hist_pkg.sv
// history entry layout and addressing
package hist_pkg;

   localparam int NB_HIST_DEPTH = 4;
   localparam int HIST_SLOTS = 2 ** NB_HIST_DEPTH;
   localparam int OFFSET_W = 7;
   localparam int HIST_W = 32;

   // entry count per LP, 0 to HIST_SLOTS
   typedef logic [NB_HIST_DEPTH:0] hist_cnt_t;
   // LP id on top of the slot number
   typedef logic [phold_pkg::NB_LPID+NB_HIST_DEPTH-1:0] hist_addr_t;
   typedef logic [OFFSET_W-1:0] offset_t;

   // offset is the distance from the entry time to the event it generated
   typedef struct packed {
      logic [HIST_W-phold_pkg::NB_LPID-OFFSET_W-phold_pkg::TIME_W-2:0] pad;
      phold_pkg::lp_id_t                                             target;
      offset_t                                                       offset;
      phold_pkg::evt_type_t                                          evt_type;
      phold_pkg::time_t                                              evt_time;
   } hist_entry_t;

endpackage

//--- verilog/event_fifo.sv
`timescale 1ns/1ns

// first-word-fall-through FIFO, head is visible on dout while not empty
module event_fifo #(
   parameter int WIDTH = 32,
   parameter int DEPTH = 16
) (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             clear,
   input  logic             wr_en,
   input  logic [WIDTH-1:0] din,
   input  logic             rd_en,
   output logic [WIDTH-1:0] dout,
   output logic             empty,
   output logic             full
);

   localparam int AW = $clog2(DEPTH);

   logic [WIDTH-1:0] mem [DEPTH];
   // extra top bit tells full from empty
   logic [AW:0]      wr_ptr;
   logic [AW:0]      rd_ptr;

   assign empty = (wr_ptr == rd_ptr);
   assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
   assign dout  = mem[rd_ptr[AW-1:0]];

   always_ff @(posedge clk) begin
      if (!rst_n || clear) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (wr_en && !full) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en && !empty) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en && !full) begin
         mem[wr_ptr[AW-1:0]] <= din;
      end
   end

endmodule

//--- verilog/hist_port.sv
`timescale 1ns/1ns

// sequences history reads and writes over the request/grant port
module hist_port (
   input  logic                  clk,
   input  logic                  rst_n,
   input  phold_pkg::lp_id_t     lp,
   input  logic                  start_read,
   input  logic                  start_write,
   input  hist_pkg::hist_cnt_t   wr_count,
   input  hist_pkg::hist_entry_t wdata,
   input  logic                  hist_grant,
   output logic                  hist_rq,
   output logic                  hist_wr,
   output hist_pkg::hist_addr_t  hist_addr,
   output hist_pkg::hist_entry_t hist_wdata,
   output logic                  rd_valid,
   output logic                  pop,
   output logic                  done
);

   typedef enum logic [1:0] {
      HP_IDLE,
      HP_REQ,
      HP_WAIT
   } hp_state_t;

   hp_state_t           state;
   // stored entries per LP
   hist_pkg::hist_cnt_t size_tab [2 ** phold_pkg::NB_LPID];
   hist_pkg::hist_cnt_t cnt;
   hist_pkg::hist_cnt_t total;
   hist_pkg::hist_cnt_t start_total;
   logic                writing;

   assign start_total = start_write ? wr_count : size_tab[lp];
   assign rd_valid    = (state == HP_WAIT) && hist_grant && !writing;
   assign pop         = (state == HP_WAIT) && hist_grant && writing;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state   <= HP_IDLE;
         cnt     <= '0;
         total   <= '0;
         writing <= 1'b0;
         hist_rq <= 1'b0;
         hist_wr <= 1'b0;
         done    <= 1'b0;
         for (int i = 0; i < 2 ** phold_pkg::NB_LPID; i++) begin
            size_tab[i] <= '0;
         end
      end else begin
         done <= 1'b0;
         case (state)
            HP_IDLE: begin
               cnt <= '0;
               if (start_read || start_write) begin
                  writing <= start_write;
                  total   <= start_total;
                  if (start_write) begin
                     size_tab[lp] <= wr_count;
                  end
                  // nothing to move, finish straight away
                  if (start_total == '0) begin
                     done <= 1'b1;
                  end else begin
                     state <= HP_REQ;
                  end
               end
            end
            HP_REQ: begin
               hist_rq <= 1'b1;
               hist_wr <= writing;
               state   <= HP_WAIT;
            end
            HP_WAIT: begin
               if (hist_grant) begin
                  hist_rq <= 1'b0;
                  hist_wr <= 1'b0;
                  cnt     <= cnt + 1'b1;
                  if (cnt == total - 1'b1) begin
                     state <= HP_IDLE;
                     done  <= 1'b1;
                  end else begin
                     state <= HP_REQ;
                  end
               end
            end
            default: state <= HP_IDLE;
         endcase
      end
   end

   // address and data captured as the request goes up
   always_ff @(posedge clk) begin
      if (state == HP_REQ) begin
         hist_addr  <= {lp, cnt[hist_pkg::NB_HIST_DEPTH-1:0]};
         hist_wdata <= wdata;
      end
   end

   a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
      hist_rq && !hist_grant |=> hist_rq && $stable(hist_addr) && $stable(hist_wdata));

endmodule

//--- verilog/rollback_filter.sv
`timescale 1ns/1ns

// sorts each history entry into drop, keep or rollback
module rollback_filter (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  clear,
   input  logic                  entry_valid,
   input  hist_pkg::hist_entry_t entry,
   input  phold_pkg::evt_type_t  cur_type,
   input  phold_pkg::time_t      cur_time,
   input  phold_pkg::time_t      gvt,
   output logic                  keep,
   output logic                  rollback,
   output logic                  discard_cur,
   output phold_pkg::evt_msg_t   cancel_msg,
   output logic                  cancel_valid
);

   logic expired;
   logic match;
   logic later;
   logic annihilate;

   always_comb begin
      // older than GVT, can never be rolled back
      expired = entry.evt_time < gvt;
      // only the first opposite-type pair annihilates
      match = (entry.evt_type != cur_type) && (entry.evt_time == cur_time) && !discard_cur;
      later = (cur_type == phold_pkg::EVT_REGULAR) &&
              (entry.evt_type == phold_pkg::EVT_REGULAR) &&
              (entry.evt_time > cur_time);
      annihilate = entry_valid && !expired && match;
      keep       = entry_valid && !expired && !match && !later;
      rollback   = entry_valid && !expired && !match && later;
   end

   always_ff @(posedge clk) begin
      if (!rst_n || clear) begin
         discard_cur  <= 1'b0;
         cancel_valid <= 1'b0;
      end else if (annihilate) begin
         discard_cur <= 1'b1;
         // a cancel undoes an event that already sent its successor
         if (cur_type == phold_pkg::EVT_CANCEL) begin
            cancel_valid <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (annihilate && cur_type == phold_pkg::EVT_CANCEL) begin
         cancel_msg          <= '0;
         cancel_msg.evt_type <= phold_pkg::EVT_CANCEL;
         cancel_msg.target   <= entry.target;
         cancel_msg.evt_time <= entry.evt_time + phold_pkg::time_t'(entry.offset);
      end
   end

endmodule

//--- verilog/event_gen.sv
`timescale 1ns/1ns

// successor event and random processing delay
module event_gen (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 load,
   input  phold_pkg::rnd_t      rnd,
   input  phold_pkg::time_t     cur_time,
   input  phold_pkg::lp_id_t    lp_mask,
   input  logic                 delay_run,
   output logic                 delay_done,
   output phold_pkg::time_t     new_time,
   output phold_pkg::lp_id_t    new_target,
   output hist_pkg::offset_t    new_offset
);

   // longest delay is FIXED_DELAY + 15
   logic [4:0] delay_lim;
   logic [4:0] delay_cnt;

   always_ff @(posedge clk) begin
      if (load) begin
         new_time   <= cur_time + phold_pkg::time_t'(phold_pkg::MIN_GAP) +
                       phold_pkg::time_t'(rnd[5:0]);
         new_offset <= hist_pkg::offset_t'(phold_pkg::MIN_GAP) + hist_pkg::offset_t'(rnd[5:0]);
         new_target <= rnd[8 +: phold_pkg::NB_LPID] & lp_mask;
         delay_lim  <= 5'(phold_pkg::FIXED_DELAY) + 5'(rnd[19:16]);
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n || !delay_run) begin
         delay_cnt <= '0;
      end else if (!delay_done) begin
         delay_cnt <= delay_cnt + 1'b1;
      end
   end

   // fires in the last cycle of the delay
   assign delay_done = delay_run && (delay_cnt == delay_lim - 1'b1);

endmodule

//--- verilog/phold_core.sv
`timescale 1ns/1ns

// one PHOLD processing core, one event in flight at a time
module phold_core (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  event_valid,
   input  phold_pkg::evt_msg_t   event_msg,
   input  phold_pkg::time_t      global_time,
   input  phold_pkg::rnd_t       random_in,
   input  phold_pkg::lp_id_t     lp_mask,
   input  logic                  ack,
   input  hist_pkg::hist_entry_t hist_rdata,
   input  logic                  hist_grant,
   output logic                  ready,
   output logic                  out_valid,
   output phold_pkg::evt_msg_t   out_msg,
   output logic                  hist_rq,
   output logic                  hist_wr,
   output hist_pkg::hist_addr_t  hist_addr,
   output hist_pkg::hist_entry_t hist_wdata
);

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_READ_HIST,
      ST_PROC_DELAY,
      ST_GEN_EVT,
      ST_WRITE_HIST,
      ST_SEND_RBK,
      ST_SEND_FINAL
   } state_t;

   state_t                state;
   logic                  accept;
   logic                  rd_start;
   logic                  wr_start;
   logic                  hist_done;
   logic                  rd_valid;
   logic                  hist_pop;
   logic                  rd_vld_q;
   hist_pkg::hist_entry_t rd_entry;

   phold_pkg::lp_id_t     cur_lp;
   phold_pkg::evt_type_t  cur_type;
   phold_pkg::time_t      cur_time;
   phold_pkg::time_t      gvt;

   logic                  filt_keep;
   logic                  filt_rbk;
   logic                  discard_cur;
   logic                  cancel_valid;
   phold_pkg::evt_msg_t   cancel_msg;

   logic                  delay_done;
   phold_pkg::time_t      new_time;
   phold_pkg::lp_id_t     new_target;
   hist_pkg::offset_t     new_offset;

   logic                  push_retain;
   logic                  retain_full;
   logic                  rbk_full;
   logic                  rbk_empty;
   hist_pkg::hist_entry_t new_entry;
   hist_pkg::hist_entry_t retain_din;
   hist_pkg::hist_entry_t retain_dout;
   hist_pkg::hist_entry_t rbk_dout;
   hist_pkg::hist_cnt_t   retain_cnt;

   // high while the regular half of a rollback pair is pending
   logic                  pair_hi;
   logic                  load_msg;
   logic                  rbk_pop;
   phold_pkg::evt_msg_t   next_msg;
   phold_pkg::evt_msg_t   final_msg;
   phold_pkg::evt_msg_t   rbk_cncl_msg;
   phold_pkg::evt_msg_t   rbk_reg_msg;

   assign ready  = (state == ST_IDLE);
   assign accept = event_valid && ready;

   always_comb begin
      new_entry          = '0;
      new_entry.target   = new_target;
      new_entry.offset   = new_offset;
      new_entry.evt_type = cur_type;
      new_entry.evt_time = cur_time;
      retain_din  = (state == ST_GEN_EVT) ? new_entry : rd_entry;
      // new entry only if this event survived and there is room
      push_retain = filt_keep || (state == ST_GEN_EVT && !discard_cur && !retain_full);
   end

   // rollback pair, cancel of the sent successor then a replay of the entry
   always_comb begin
      rbk_cncl_msg          = '0;
      rbk_cncl_msg.evt_type = phold_pkg::EVT_CANCEL;
      rbk_cncl_msg.target   = rbk_dout.target;
      rbk_cncl_msg.evt_time = rbk_dout.evt_time + phold_pkg::time_t'(rbk_dout.offset);
      rbk_reg_msg           = '0;
      rbk_reg_msg.evt_type  = phold_pkg::EVT_REGULAR;
      rbk_reg_msg.target    = cur_lp;
      rbk_reg_msg.evt_time  = rbk_dout.evt_time;
   end

   always_comb begin
      // null message by default
      final_msg          = '0;
      final_msg.evt_type = phold_pkg::EVT_CANCEL;
      if (discard_cur) begin
         if (cancel_valid) begin
            final_msg = cancel_msg;
         end
      end else if (cur_type == phold_pkg::EVT_REGULAR) begin
         final_msg.evt_type = phold_pkg::EVT_REGULAR;
         final_msg.target   = new_target;
         final_msg.evt_time = new_time;
      end
      final_msg.is_final = 1'b1;

      load_msg = (state == ST_SEND_RBK) && !out_valid;
      next_msg = final_msg;
      if (!rbk_empty) begin
         next_msg = pair_hi ? rbk_reg_msg : rbk_cncl_msg;
      end
   end

   assign rbk_pop = (state == ST_SEND_RBK) && out_valid && ack && pair_hi;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state      <= ST_IDLE;
         out_valid  <= 1'b0;
         pair_hi    <= 1'b0;
         rd_start   <= 1'b0;
         wr_start   <= 1'b0;
         rd_vld_q   <= 1'b0;
         retain_cnt <= '0;
      end else begin
         rd_start <= accept;
         wr_start <= (state == ST_GEN_EVT);
         rd_vld_q <= rd_valid;
         if (state == ST_IDLE) begin
            retain_cnt <= '0;
         end else if (push_retain) begin
            retain_cnt <= retain_cnt + 1'b1;
         end
         case (state)
            ST_IDLE:       if (accept) state <= ST_READ_HIST;
            ST_READ_HIST:  if (hist_done) state <= ST_PROC_DELAY;
            ST_PROC_DELAY: if (delay_done) state <= ST_GEN_EVT;
            ST_GEN_EVT:    state <= ST_WRITE_HIST;
            ST_WRITE_HIST: if (hist_done) state <= ST_SEND_RBK;
            ST_SEND_RBK: begin
               if (!out_valid) begin
                  out_valid <= 1'b1;
                  if (rbk_empty) begin
                     state <= ST_SEND_FINAL;
                  end
               end else if (ack) begin
                  out_valid <= 1'b0;
                  pair_hi   <= !pair_hi;
               end
            end
            ST_SEND_FINAL: begin
               if (ack) begin
                  out_valid <= 1'b0;
                  state     <= ST_IDLE;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         cur_lp   <= event_msg.target;
         cur_type <= event_msg.evt_type;
         cur_time <= event_msg.evt_time;
         gvt      <= global_time;
      end
      if (rd_valid) begin
         rd_entry <= hist_rdata;
      end
      if (load_msg) begin
         out_msg <= next_msg;
      end
   end

   hist_port u_hist_port (
      .clk         (clk),
      .rst_n       (rst_n),
      .lp          (cur_lp),
      .start_read  (rd_start),
      .start_write (wr_start),
      .wr_count    (retain_cnt),
      .wdata       (retain_dout),
      .hist_grant  (hist_grant),
      .hist_rq     (hist_rq),
      .hist_wr     (hist_wr),
      .hist_addr   (hist_addr),
      .hist_wdata  (hist_wdata),
      .rd_valid    (rd_valid),
      .pop         (hist_pop),
      .done        (hist_done)
   );

   rollback_filter u_filter (
      .clk          (clk),
      .rst_n        (rst_n),
      .clear        (state == ST_IDLE),
      .entry_valid  (rd_vld_q),
      .entry        (rd_entry),
      .cur_type     (cur_type),
      .cur_time     (cur_time),
      .gvt          (gvt),
      .keep         (filt_keep),
      .rollback     (filt_rbk),
      .discard_cur  (discard_cur),
      .cancel_msg   (cancel_msg),
      .cancel_valid (cancel_valid)
   );

   event_gen u_event_gen (
      .clk        (clk),
      .rst_n      (rst_n),
      .load       (accept),
      .rnd        (random_in),
      .cur_time   (event_msg.evt_time),
      .lp_mask    (lp_mask),
      .delay_run  (state == ST_PROC_DELAY),
      .delay_done (delay_done),
      .new_time   (new_time),
      .new_target (new_target),
      .new_offset (new_offset)
   );

   event_fifo #(.WIDTH(hist_pkg::HIST_W), .DEPTH(hist_pkg::HIST_SLOTS)) retain_fifo (
      .clk   (clk),
      .rst_n (rst_n),
      .clear (state == ST_IDLE),
      .wr_en (push_retain),
      .din   (retain_din),
      .rd_en (hist_pop),
      .dout  (retain_dout),
      .empty (),
      .full  (retain_full)
   );

   event_fifo #(.WIDTH(hist_pkg::HIST_W), .DEPTH(hist_pkg::HIST_SLOTS)) rbk_fifo (
      .clk   (clk),
      .rst_n (rst_n),
      .clear (state == ST_IDLE),
      .wr_en (filt_rbk),
      .din   (rd_entry),
      .rd_en (rbk_pop),
      .dout  (rbk_dout),
      .empty (rbk_empty),
      .full  (rbk_full)
   );

   a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid && !ack |=> out_valid && $stable(out_msg));

   a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
      !(push_retain && retain_full) && !(filt_rbk && rbk_full));

endmodule

//--- verif/tb_ref.svh
`ifndef TB_REF_SVH
`define TB_REF_SVH

// reference state, per-LP history and pending expectations
hist_pkg::hist_entry_t ref_hist [8][16];
int                    ref_size [8];
phold_pkg::evt_msg_t   exp_msgs [$];
hist_pkg::hist_entry_t exp_wr [$];
hist_pkg::hist_addr_t  exp_addr [$];
int                    errors;
int                    checks;
logic [15:0]           stim_lfsr = 16'd31;
logic [15:0]           port_lfsr = 16'd31;

function automatic logic [15:0] lfsr_step(input logic [15:0] s);
   logic [15:0] n;
   n = s >> 1;
   // taps 16 14 13 11
   if (s[0]) begin
      n = n ^ 16'hB400;
   end
   return n;
endfunction

function automatic logic [31:0] stim_bits(input int n);
   logic [31:0] v;
   v = '0;
   for (int i = 0; i < n; i++) begin
      v = {v[30:0], stim_lfsr[0]};
      stim_lfsr = lfsr_step(stim_lfsr);
   end
   return v;
endfunction

// separate stream for grant and ack timing
function automatic logic [31:0] port_bits(input int n);
   logic [31:0] v;
   v = '0;
   for (int i = 0; i < n; i++) begin
      v = {v[30:0], port_lfsr[0]};
      port_lfsr = lfsr_step(port_lfsr);
   end
   return v;
endfunction

function automatic phold_pkg::evt_msg_t make_msg(input logic fin,
                                                 input phold_pkg::evt_type_t ty,
                                                 input phold_pkg::lp_id_t tg,
                                                 input phold_pkg::time_t t);
   phold_pkg::evt_msg_t m;
   m          = '0;
   m.is_final = fin;
   m.evt_type = ty;
   m.target   = tg;
   m.evt_time = t;
   return m;
endfunction

// queues the messages and history writes one event should produce
function automatic void expect_event(input phold_pkg::evt_msg_t ev, input phold_pkg::time_t g,
                                     input phold_pkg::rnd_t rnd, input phold_pkg::lp_id_t mask);
   hist_pkg::hist_entry_t kept [16];
   hist_pkg::hist_entry_t rbk [16];
   hist_pkg::hist_entry_t e;
   phold_pkg::evt_msg_t   cmsg;
   phold_pkg::evt_msg_t   fin;
   phold_pkg::lp_id_t     lp;
   int                    nk;
   int                    nr;
   logic                  disc;
   logic                  cvalid;
   lp     = ev.target;
   nk     = 0;
   nr     = 0;
   disc   = 1'b0;
   cvalid = 1'b0;
   cmsg   = '0;
   for (int i = 0; i < ref_size[lp]; i++) begin
      e = ref_hist[lp][i];
      if (e.evt_time < g) begin
         // pruned below GVT
      end else if (e.evt_type != ev.evt_type && e.evt_time == ev.evt_time && !disc) begin
         disc = 1'b1;
         if (ev.evt_type == phold_pkg::EVT_CANCEL) begin
            cvalid = 1'b1;
            cmsg   = make_msg(1'b1, phold_pkg::EVT_CANCEL, e.target,
                              e.evt_time + phold_pkg::time_t'(e.offset));
         end
      end else if (ev.evt_type == phold_pkg::EVT_REGULAR &&
                   e.evt_type == phold_pkg::EVT_REGULAR && e.evt_time > ev.evt_time) begin
         rbk[nr] = e;
         nr++;
      end else begin
         kept[nk] = e;
         nk++;
      end
   end
   if (!disc && nk < 16) begin
      e          = '0;
      e.target   = rnd[10:8] & mask;
      e.offset   = 7'(phold_pkg::MIN_GAP + rnd[5:0]);
      e.evt_type = ev.evt_type;
      e.evt_time = ev.evt_time;
      kept[nk]   = e;
      nk++;
   end
   ref_size[lp] = nk;
   for (int i = 0; i < nk; i++) begin
      ref_hist[lp][i] = kept[i];
      exp_wr.push_back(kept[i]);
      exp_addr.push_back({lp, 4'(i)});
   end
   for (int i = 0; i < nr; i++) begin
      exp_msgs.push_back(make_msg(1'b0, phold_pkg::EVT_CANCEL, rbk[i].target,
                                  rbk[i].evt_time + phold_pkg::time_t'(rbk[i].offset)));
      exp_msgs.push_back(make_msg(1'b0, phold_pkg::EVT_REGULAR, lp, rbk[i].evt_time));
   end
   fin = make_msg(1'b1, phold_pkg::EVT_CANCEL, '0, '0);
   if (disc) begin
      if (cvalid) begin
         fin = cmsg;
      end
   end else if (ev.evt_type == phold_pkg::EVT_REGULAR) begin
      fin = make_msg(1'b1, phold_pkg::EVT_REGULAR, rnd[10:8] & mask,
                     ev.evt_time + phold_pkg::time_t'(phold_pkg::MIN_GAP + rnd[5:0]));
   end
   exp_msgs.push_back(fin);
endfunction

task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
   checks++;
   if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
   end
endtask

`endif

//--- verif/tb_phold_core.sv
`timescale 1ns/1ns

module tb_phold_core;

   localparam int N_EVENTS = 68;

   logic                  clk;
   logic                  rst_n;
   logic                  event_valid;
   phold_pkg::evt_msg_t   event_msg;
   phold_pkg::time_t      global_time;
   phold_pkg::rnd_t       random_in;
   phold_pkg::lp_id_t     lp_mask;
   logic                  ack;
   hist_pkg::hist_entry_t hist_rdata;
   logic                  hist_grant;
   logic                  ready;
   logic                  out_valid;
   phold_pkg::evt_msg_t   out_msg;
   logic                  hist_rq;
   logic                  hist_wr;
   hist_pkg::hist_addr_t  hist_addr;
   hist_pkg::hist_entry_t hist_wdata;

   // history memory of 8 LPs with 16 slots each
   hist_pkg::hist_entry_t mem [128];
   phold_pkg::time_t      gvt_level;
   logic                  g_pend;
   logic                  a_pend;
   int                    g_wait;
   int                    a_wait;
   // message seen waiting for ack on the previous edge
   logic                  held;
   phold_pkg::evt_msg_t   held_msg;
   logic                  fin_acked;

   `include "tb_ref.svh"

   phold_core u_dut (
      .clk         (clk),
      .rst_n       (rst_n),
      .event_valid (event_valid),
      .event_msg   (event_msg),
      .global_time (global_time),
      .random_in   (random_in),
      .lp_mask     (lp_mask),
      .ack         (ack),
      .hist_rdata  (hist_rdata),
      .hist_grant  (hist_grant),
      .ready       (ready),
      .out_valid   (out_valid),
      .out_msg     (out_msg),
      .hist_rq     (hist_rq),
      .hist_wr     (hist_wr),
      .hist_addr   (hist_addr),
      .hist_wdata  (hist_wdata)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // grant and ack come 0 to 3 random cycles late and last one cycle
   always @(negedge clk) begin
      if (rst_n) begin
         if (hist_grant) begin
            hist_grant = 1'b0;
            g_pend     = 1'b0;
         end else if (hist_rq) begin
            if (!g_pend) begin
               g_pend = 1'b1;
               g_wait = port_bits(2);
            end
            if (g_wait == 0) begin
               hist_grant = 1'b1;
               if (hist_wr) begin
                  mem[hist_addr] = hist_wdata;
               end else begin
                  hist_rdata = mem[hist_addr];
               end
            end else begin
               g_wait--;
            end
         end
         if (ack) begin
            ack    = 1'b0;
            a_pend = 1'b0;
         end else if (out_valid) begin
            if (!a_pend) begin
               a_pend = 1'b1;
               a_wait = port_bits(2);
            end
            if (a_wait == 0) begin
               ack = 1'b1;
            end else begin
               a_wait--;
            end
         end
      end
   end

   // compare messages at ack and history writes at grant
   always @(posedge clk) begin
      phold_pkg::evt_msg_t   m;
      hist_pkg::hist_entry_t w;
      hist_pkg::hist_addr_t  a;
      if (held) begin
         check(32'(out_valid), 32'd1, "out_valid held until ack");
         check(out_msg, held_msg, "out_msg held until ack");
      end
      if (fin_acked) begin
         check(32'(ready), 32'd1, "ready after final ack");
      end
      held      = rst_n && out_valid && !ack;
      held_msg  = out_msg;
      fin_acked = rst_n && out_valid && ack && out_msg.is_final;
      if (rst_n && out_valid && ack) begin
         if (exp_msgs.size() == 0) begin
            errors++;
            $display("unexpected output message %h at %0t with none pending", out_msg, $time);
         end else begin
            m = exp_msgs.pop_front();
            check(out_msg, m, "out_msg");
         end
      end
      if (rst_n && hist_rq && hist_grant && hist_wr) begin
         if (exp_wr.size() == 0) begin
            errors++;
            $display("unexpected history write to %h at %0t", hist_addr, $time);
         end else begin
            w = exp_wr.pop_front();
            a = exp_addr.pop_front();
            check(hist_wdata, w, "hist_wdata");
            check(32'(hist_addr), 32'(a), "hist_addr");
         end
      end
   end

   task automatic send_event(input phold_pkg::lp_id_t lp, input phold_pkg::evt_type_t ty,
                             input phold_pkg::time_t t);
      phold_pkg::evt_msg_t m;
      phold_pkg::rnd_t     r;
      m = make_msg(1'b0, ty, lp, t);
      r = stim_bits(phold_pkg::NB_RND);
      expect_event(m, gvt_level, r, lp_mask);
      event_msg   = m;
      random_in   = r;
      global_time = gvt_level;
      event_valid = 1'b1;
      @(negedge clk);
      event_valid = 1'b0;
      @(negedge clk);
      while (!(ready && exp_msgs.size() == 0)) begin
         @(negedge clk);
      end
      if (exp_wr.size() != 0) begin
         errors++;
         $display("event at %0t finished with %0d history writes missing", $time, exp_wr.size());
         exp_wr.delete();
         exp_addr.delete();
      end
   endtask

   initial begin
      repeat (N_EVENTS * 2000) @(posedge clk);
      $display("watchdog expired after %0d cycles, DUT stopped responding", N_EVENTS * 2000);
      $display("Simulation FAILED");
      $finish;
   end

   initial begin
      rst_n       = 1'b0;
      event_valid = 1'b0;
      event_msg   = '0;
      global_time = '0;
      random_in   = '0;
      lp_mask     = 3'b111;
      ack         = 1'b0;
      hist_rdata  = '0;
      hist_grant  = 1'b0;
      g_pend      = 1'b0;
      a_pend      = 1'b0;
      g_wait      = 0;
      a_wait      = 0;
      held        = 1'b0;
      held_msg    = '0;
      fin_acked   = 1'b0;
      gvt_level   = '0;
      errors      = 0;
      checks      = 0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      check(32'(ready), 32'd1, "ready after reset");
      check(32'(out_valid), 32'd0, "out_valid after reset");
      check(32'(hist_rq), 32'd0, "hist_rq after reset");
      check(32'(hist_wr), 32'd0, "hist_wr after reset");
      // first event per LP into empty history
      for (int i = 0; i < 8; i++) begin
         send_event(3'(i), phold_pkg::EVT_REGULAR, 16'(100 + 5 * i));
      end
      // random regular traffic at GVT 0
      for (int i = 0; i < 40; i++) begin
         send_event(3'(stim_bits(3)), phold_pkg::EVT_REGULAR, 16'(20 + stim_bits(8)));
      end
      // raised GVT prunes old entries
      gvt_level = 16'd150;
      lp_mask   = 3'b101;
      for (int i = 0; i < 16; i++) begin
         send_event(3'(stim_bits(3)), phold_pkg::EVT_REGULAR, 16'(150 + stim_bits(7)));
      end
      lp_mask = 3'b111;
      // cancel hits a stored regular entry
      send_event(3'd2, phold_pkg::EVT_REGULAR, 16'd400);
      send_event(3'd2, phold_pkg::EVT_CANCEL, 16'd400);
      // regular hits a stored cancel entry
      send_event(3'd5, phold_pkg::EVT_CANCEL, 16'd900);
      send_event(3'd5, phold_pkg::EVT_REGULAR, 16'd900);
      repeat (4) @(negedge clk);
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

//--- sources.f
+incdir+verif
verilog/phold_pkg.sv
verilog/hist_pkg.sv
verilog/event_fifo.sv
verilog/hist_port.sv
verilog/rollback_filter.sv
verilog/event_gen.sv
verilog/phold_core.sv
verif/tb_phold_core.sv
